// File: hw/alu_pkg.sv
/*
 * Shared types and constants for the integer ALU.
 * Opcodes, flag positions, FSM state types and widths used across the design.
 */

package alu_pkg;

    // Data path widths
    localparam int DATA_W = 32;
    localparam int HALF_W = DATA_W / 2;
    localparam int CNT_W  = $clog2(DATA_W);

    // Flag vector layout
    localparam int FLAG_W    = 2;
    localparam int FLAG_ZERO = 0;
    localparam int FLAG_ERR  = 1;

    // IEEE single precision fields
    localparam int EXP_W    = 8;
    localparam int MANT_W   = 23;
    localparam int EXP_BIAS = 127;

    // 00xx arithmetic, 01xx bitwise, 1xxx special
    typedef enum logic [3:0] {
        OP_ADD        = 4'd0,
        OP_SUB        = 4'd1,
        OP_MUL        = 4'd2,
        OP_DIV        = 4'd3,
        OP_NOT        = 4'd4,
        OP_AND        = 4'd5,
        OP_OR         = 4'd6,
        OP_XOR        = 4'd7,
        OP_WRITE_HIGH = 4'd8,
        OP_WRITE_LOW  = 4'd9,
        OP_ITOF       = 4'd10,
        OP_FTOI       = 4'd11
    } alu_op_e;

    // Function select inside the arithmetic unit
    typedef enum logic [1:0] {
        FN_ADD = 2'd0,
        FN_SUB = 2'd1,
        FN_MUL = 2'd2,
        FN_DIV = 2'd3
    } arith_fn_e;

    typedef enum logic [1:0] {IDLE, BUSY, DONE} unit_state_e;

    typedef enum logic [1:0] {WAIT_REQ, WAIT_UNIT, HOLD_ACK} disp_state_e;

endpackage

// File: hw/exec_if.sv
/*
 * Link between the dispatcher and one execution unit.
 * start and done are single-cycle pulses; operands are held until done.
 */

`timescale 1ns/1ps

interface exec_if;

    logic                              start;
    logic signed [alu_pkg::DATA_W-1:0] a;
    logic signed [alu_pkg::DATA_W-1:0] b;
    alu_pkg::arith_fn_e                fn;
    logic                              done;
    logic        [alu_pkg::DATA_W-1:0] res;
    logic        [alu_pkg::FLAG_W-1:0] flg;

    // Dispatcher side
    modport disp (output start, a, b, fn, input done, res, flg);

    // Execution unit side
    modport unit (input start, a, b, fn, output done, res, flg);

endinterface

// File: hw/int_arith_unit.sv
/*
 * Iterative signed add, subtract, multiply and divide.
 * Add and sub finish in one cycle, multiply in 32 and divide in 33.
 */

`timescale 1ns/1ps

module int_arith_unit (
    input  logic clk,
    input  logic arst_n,
    exec_if.unit io
);

    localparam int W = alu_pkg::DATA_W;

    alu_pkg::unit_state_e          state;
    alu_pkg::arith_fn_e            fn_q;
    alu_pkg::arith_fn_e            fn_sel;
    logic [alu_pkg::CNT_W-1:0]     cnt;
    logic                          neg;
    logic                          div_zero;
    logic                          ovf;
    logic [W-1:0]                  mag_a;
    logic [W-1:0]                  mag_b;
    logic [W-1:0]                  sum;
    logic [W-1:0]                  diff;
    logic [2*W-1:0]                acc;
    logic [2*W-1:0]                acc_nxt;
    logic [2*W-1:0]                mcand;
    logic [2*W-1:0]                prod;
    logic [W-1:0]                  mplier;
    logic [W-1:0]                  quo;
    logic [W-1:0]                  quo_nxt;
    logic [W-1:0]                  rem;
    logic [W-1:0]                  rem_nxt;
    logic [W-1:0]                  dvs;
    logic [W:0]                    rem_sh;
    logic                          rem_ge;
    logic [W-1:0]                  div_res;
    logic [W-1:0]                  res_nxt;
    logic [alu_pkg::FLAG_W-1:0]    flg_nxt;

    assign io.done = (state == alu_pkg::DONE);

    assign mag_a = io.a[W-1] ? -io.a : io.a;
    assign mag_b = io.b[W-1] ? -io.b : io.b;
    assign sum   = io.a + io.b;
    assign diff  = io.a - io.b;

    // One shift-and-add step on the magnitudes
    assign acc_nxt = mplier[0] ? acc + mcand : acc;
    assign prod    = neg ? -acc_nxt : acc_nxt;

    // One restoring division step
    assign rem_sh  = {rem, quo[W-1]};
    assign rem_ge  = (rem_sh >= {1'b0, dvs});
    assign rem_nxt = rem_ge ? rem_sh[W-1:0] - dvs : rem_sh[W-1:0];
    assign quo_nxt = {quo[W-2:0], rem_ge};
    assign div_res = div_zero ? '1 : (neg ? -quo_nxt : quo_nxt);

    always_comb begin
        fn_sel = (state == alu_pkg::IDLE) ? io.fn : fn_q;
        case (fn_sel)
            alu_pkg::FN_ADD: begin
                res_nxt = sum;
                ovf     = (io.a[W-1] == io.b[W-1]) && (sum[W-1] != io.a[W-1]);
            end
            alu_pkg::FN_SUB: begin
                res_nxt = diff;
                ovf     = (io.a[W-1] != io.b[W-1]) && (diff[W-1] != io.a[W-1]);
            end
            alu_pkg::FN_MUL: begin
                res_nxt = prod[W-1:0];
                // Upper half must be a sign extension of the low word
                ovf     = !((&prod[2*W-1:W-1]) || !(|prod[2*W-1:W-1]));
            end
            default: begin
                res_nxt = div_res;
                ovf     = div_zero;
            end
        endcase
        flg_nxt = '0;
        flg_nxt[alu_pkg::FLAG_ZERO] = (res_nxt == '0);
        flg_nxt[alu_pkg::FLAG_ERR]  = ovf;
    end

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= alu_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                alu_pkg::IDLE: begin
                    if (io.start) begin
                        if (io.fn == alu_pkg::FN_ADD || io.fn == alu_pkg::FN_SUB)
                            state <= alu_pkg::DONE;
                        else
                            state <= alu_pkg::BUSY;
                        // Multiply does its first step on the start edge
                        cnt <= (io.fn == alu_pkg::FN_MUL) ? alu_pkg::CNT_W'(1) : '0;
                    end
                end
                alu_pkg::BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (&cnt)
                        state <= alu_pkg::DONE;
                end
                default: state <= alu_pkg::IDLE;
            endcase
        end
    end

    ////////////////////
    // Data path
    ////////////////////

    always_ff @(posedge clk) begin
        if (state == alu_pkg::IDLE && io.start) begin
            fn_q     <= io.fn;
            neg      <= io.a[W-1] ^ io.b[W-1];
            div_zero <= (io.b == '0);
            acc      <= mag_b[0] ? {{W{1'b0}}, mag_a} : '0;
            mcand    <= {{(W-1){1'b0}}, mag_a, 1'b0};
            mplier   <= mag_b >> 1;
            quo      <= mag_a;
            rem      <= '0;
            dvs      <= mag_b;
            io.res   <= res_nxt;
            io.flg   <= flg_nxt;
        end else if (state == alu_pkg::BUSY) begin
            if (fn_q == alu_pkg::FN_MUL) begin
                acc    <= acc_nxt;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end else begin
                quo <= quo_nxt;
                rem <= rem_nxt;
            end
            io.res <= res_nxt;
            io.flg <= flg_nxt;
        end
    end

    // A start that arrives while busy would be lost
    start_in_idle: assert property (@(posedge clk) disable iff (!arst_n)
        io.start |-> state == alu_pkg::IDLE);

endmodule

// File: hw/int_to_float.sv
/*
 * Signed integer to IEEE single precision, truncating.
 * Normalizes one bit per cycle; zero converts to +0.0.
 */

`timescale 1ns/1ps

module int_to_float (
    input  logic clk,
    input  logic arst_n,
    exec_if.unit io
);

    localparam int W = alu_pkg::DATA_W;

    alu_pkg::unit_state_e        state;
    logic                        sign;
    logic [alu_pkg::EXP_W-1:0]   exp_q;
    logic [W-1:0]                mag;

    assign io.done = (state == alu_pkg::DONE);
    assign io.flg  = '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= alu_pkg::IDLE;
        end else begin
            case (state)
                alu_pkg::IDLE: begin
                    if (io.start)
                        state <= (io.a == '0) ? alu_pkg::DONE : alu_pkg::BUSY;
                end
                alu_pkg::BUSY: begin
                    if (mag[W-1])
                        state <= alu_pkg::DONE;
                end
                default: state <= alu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == alu_pkg::IDLE && io.start) begin
            sign   <= io.a[W-1];
            mag    <= io.a[W-1] ? -io.a : io.a;
            // Exponent if the leading one were already at the top bit
            exp_q  <= alu_pkg::EXP_W'(alu_pkg::EXP_BIAS + W - 1);
            io.res <= '0;
        end else if (state == alu_pkg::BUSY) begin
            if (mag[W-1]) begin
                // Hidden bit dropped, low bits truncated
                io.res <= {sign, exp_q, mag[W-2 -: alu_pkg::MANT_W]};
            end else begin
                mag   <= mag << 1;
                exp_q <= exp_q - 1'b1;
            end
        end
    end

endmodule

// File: hw/float_to_int.sv
/*
 * IEEE single precision to signed integer.
 * Truncates toward zero, saturates on overflow, infinity and NaN.
 */

`timescale 1ns/1ps

module float_to_int (
    input  logic clk,
    input  logic arst_n,
    exec_if.unit io
);

    localparam int W = alu_pkg::DATA_W;

    alu_pkg::unit_state_e        state;
    logic                        sign;
    logic [alu_pkg::CNT_W-1:0]   cnt;
    logic [W-1:0]                mant;
    logic [alu_pkg::EXP_W-1:0]   exp_f;
    logic                        is_nan;
    logic                        too_small;
    logic                        too_big;
    logic [W-1:0]                special_res;

    assign io.done = (state == alu_pkg::DONE);
    assign io.flg  = '0;

    assign exp_f     = io.a[W-2 -: alu_pkg::EXP_W];
    assign is_nan    = (&exp_f) && (io.a[alu_pkg::MANT_W-1:0] != '0);
    assign too_small = (exp_f < alu_pkg::EXP_BIAS);
    // Also catches infinity and NaN
    assign too_big   = (exp_f >= alu_pkg::EXP_BIAS + W - 1);

    always_comb begin
        if (is_nan)
            special_res = {1'b0, {(W-1){1'b1}}};
        else if (too_big)
            special_res = io.a[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
        else
            special_res = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= alu_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                alu_pkg::IDLE: begin
                    if (io.start) begin
                        state <= (too_small || too_big) ? alu_pkg::DONE : alu_pkg::BUSY;
                        // Right shifts needed to reach the integer point
                        cnt   <= alu_pkg::CNT_W'(alu_pkg::EXP_BIAS + W - 1 - exp_f);
                    end
                end
                alu_pkg::BUSY: begin
                    if (cnt == '0)
                        state <= alu_pkg::DONE;
                    else
                        cnt <= cnt - 1'b1;
                end
                default: state <= alu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == alu_pkg::IDLE && io.start) begin
            sign   <= io.a[W-1];
            mant   <= {1'b1, io.a[alu_pkg::MANT_W-1:0], {(W-1-alu_pkg::MANT_W){1'b0}}};
            io.res <= special_res;
        end else if (state == alu_pkg::BUSY) begin
            if (cnt == '0)
                io.res <= sign ? -mant : mant;
            else
                mant <= mant >> 1;
        end
    end

endmodule

// File: hw/int_alu.sv
/*
 * ALU dispatcher with a four-phase req/ack handshake.
 * Finishes bitwise and pack operations locally, starts a unit for the rest.
 */

`timescale 1ns/1ps

module int_alu (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              req,
    input  logic signed [alu_pkg::DATA_W-1:0] op1,
    input  logic signed [alu_pkg::DATA_W-1:0] op2,
    input  alu_pkg::alu_op_e                  operation,
    output logic                              ack,
    output logic        [alu_pkg::DATA_W-1:0] result,
    output logic        [alu_pkg::FLAG_W-1:0] flag,
    exec_if.disp                              arith,
    exec_if.disp                              itof,
    exec_if.disp                              ftoi
);

    alu_pkg::disp_state_e          state;
    alu_pkg::alu_op_e              op_dec;
    logic [alu_pkg::DATA_W-1:0]    local_res;
    logic [alu_pkg::FLAG_W-1:0]    local_flg;
    logic                          local_done;

    // Bit 2 is ignored in the special group, so 11xx aliases 10xx
    assign op_dec = alu_pkg::alu_op_e'({operation[3], operation[2] & ~operation[3],
                                        operation[1:0]});

    // Units latch operands on start, requester holds them stable
    assign arith.a  = op1;
    assign arith.b  = op2;
    assign arith.fn = alu_pkg::arith_fn_e'(operation[1:0]);
    assign itof.a   = op1;
    assign itof.b   = op2;
    assign itof.fn  = alu_pkg::arith_fn_e'(operation[1:0]);
    assign ftoi.a   = op1;
    assign ftoi.b   = op2;
    assign ftoi.fn  = alu_pkg::arith_fn_e'(operation[1:0]);

    ////////////////////
    // Local operations
    ////////////////////

    always_comb begin
        case (op_dec)
            alu_pkg::OP_NOT:        local_res = ~op1;
            alu_pkg::OP_AND:        local_res = op1 & op2;
            alu_pkg::OP_OR:         local_res = op1 | op2;
            alu_pkg::OP_XOR:        local_res = op1 ^ op2;
            alu_pkg::OP_WRITE_HIGH: local_res = {op2[alu_pkg::HALF_W-1:0],
                                                 op1[alu_pkg::HALF_W-1:0]};
            alu_pkg::OP_WRITE_LOW:  local_res = {op1[alu_pkg::DATA_W-1:alu_pkg::HALF_W],
                                                 op2[alu_pkg::HALF_W-1:0]};
            default:                local_res = '0;
        endcase
        local_flg = '0;
        local_flg[alu_pkg::FLAG_ZERO] = (local_res == '0);
    end

    ////////////////////
    // Handshake FSM
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= alu_pkg::WAIT_REQ;
            ack         <= 1'b0;
            result      <= '0;
            flag        <= '0;
            local_done  <= 1'b0;
            arith.start <= 1'b0;
            itof.start  <= 1'b0;
            ftoi.start  <= 1'b0;
        end else begin
            // Start strobes last one cycle
            arith.start <= 1'b0;
            itof.start  <= 1'b0;
            ftoi.start  <= 1'b0;
            case (state)
                alu_pkg::WAIT_REQ: begin
                    if (req) begin
                        state      <= alu_pkg::WAIT_UNIT;
                        local_done <= 1'b0;
                        case (op_dec)
                            alu_pkg::OP_ADD, alu_pkg::OP_SUB,
                            alu_pkg::OP_MUL, alu_pkg::OP_DIV: arith.start <= 1'b1;
                            alu_pkg::OP_ITOF:                 itof.start  <= 1'b1;
                            alu_pkg::OP_FTOI:                 ftoi.start  <= 1'b1;
                            default: begin
                                result     <= local_res;
                                flag       <= local_flg;
                                local_done <= 1'b1;
                            end
                        endcase
                    end
                end
                alu_pkg::WAIT_UNIT: begin
                    // Only the started unit can report done
                    if (arith.done) begin
                        result <= arith.res;
                        flag   <= arith.flg;
                    end else if (itof.done) begin
                        result <= itof.res;
                        flag   <= itof.flg;
                    end else if (ftoi.done) begin
                        result <= ftoi.res;
                        flag   <= ftoi.flg;
                    end
                    if (local_done || arith.done || itof.done || ftoi.done) begin
                        ack   <= 1'b1;
                        state <= alu_pkg::HOLD_ACK;
                    end
                end
                alu_pkg::HOLD_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= alu_pkg::WAIT_REQ;
                    end
                end
                default: state <= alu_pkg::WAIT_REQ;
            endcase
        end
    end

    // ack answers a pending request, never an idle bus
    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> req);

    // Only one unit is ever working, and it reports while the FSM waits for it
    unit_done_expected: assert property (@(posedge clk) disable iff (!arst_n)
        (arith.done || itof.done || ftoi.done) |->
            (state == alu_pkg::WAIT_UNIT) && $onehot0({arith.done, itof.done, ftoi.done}));

endmodule

// File: hw/alu_top.sv
/*
 * ALU top level with plain handshake ports.
 * Connects the dispatcher to the arithmetic unit and both converters.
 */

`timescale 1ns/1ps

module alu_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              req,
    input  logic signed [alu_pkg::DATA_W-1:0] op1,
    input  logic signed [alu_pkg::DATA_W-1:0] op2,
    input  logic        [3:0]                 operation,
    output logic                              ack,
    output logic        [alu_pkg::DATA_W-1:0] result,
    output logic        [alu_pkg::FLAG_W-1:0] flag
);

    exec_if arith_if ();
    exec_if itof_if ();
    exec_if ftoi_if ();

    int_alu int_alu_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .op1       (op1),
        .op2       (op2),
        .operation (alu_pkg::alu_op_e'(operation)),
        .ack       (ack),
        .result    (result),
        .flag      (flag),
        .arith     (arith_if.disp),
        .itof      (itof_if.disp),
        .ftoi      (ftoi_if.disp)
    );

    int_arith_unit int_arith_unit_i (
        .clk    (clk),
        .arst_n (arst_n),
        .io     (arith_if.unit)
    );

    int_to_float int_to_float_i (
        .clk    (clk),
        .arst_n (arst_n),
        .io     (itof_if.unit)
    );

    float_to_int float_to_int_i (
        .clk    (clk),
        .arst_n (arst_n),
        .io     (ftoi_if.unit)
    );

endmodule

// File: sim/tb_clock.sv
/*
 * Clock and reset source for the ALU testbench.
 * 100 ns clock period, reset held low for the first 10 cycles.
 */

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: sim/tb_alu.sv
/*
 * Directed testbench for the ALU top level.
 * Runs four-phase transactions and compares against models in the testbench.
 */

`timescale 1ns/1ps

module tb_alu;

    localparam int TIMEOUT = 200;

    logic        clk;
    logic        arst_n;
    logic        req;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [3:0]  operation;
    logic        ack;
    logic [31:0] result;
    logic [1:0]  flag;

    int          seed = 95;
    int          checks = 0;
    int          errors = 0;
    bit          timed_out = 1'b0;
    logic        ack_at_reset;
    logic [31:0] res_at_reset;
    logic [1:0]  flg_at_reset;

    tb_clock tb_clock_i (.clk(clk), .arst_n(arst_n));

    alu_top alu_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .op1       (op1),
        .op2       (op2),
        .operation (operation),
        .ack       (ack),
        .result    (result),
        .flag      (flag)
    );

    ////////////////////
    // Reference models
    ////////////////////

    task automatic arith_expect(input logic [3:0] code, input int a, input int b,
                                output logic [31:0] res, output logic [1:0] flg);
        longint wide;
        flg = '0;
        case (code[1:0])
            2'd0: wide = longint'(a) + longint'(b);
            2'd1: wide = longint'(a) - longint'(b);
            2'd2: wide = longint'(a) * longint'(b);
            default: begin
                if (b == 0)
                    wide = -64'sd1;
                else
                    wide = longint'(a) / longint'(b);
            end
        endcase
        res = wide[31:0];
        if (code[1:0] == 2'd3)
            flg[alu_pkg::FLAG_ERR] = (b == 0);
        else
            flg[alu_pkg::FLAG_ERR] = (wide != longint'($signed(res)));
        flg[alu_pkg::FLAG_ZERO] = (res == 32'd0);
    endtask

    function automatic logic [1:0] zero_only(input logic [31:0] r);
        logic [1:0] f;
        f = '0;
        f[alu_pkg::FLAG_ZERO] = (r == 32'd0);
        return f;
    endfunction

    // Truncating int to float, leading one found by scan
    function automatic logic [31:0] float_from_int(input logic [31:0] v);
        logic [31:0] mag;
        logic [31:0] frac;
        int          top;
        int          k;
        if (v == 32'd0)
            return 32'd0;
        mag = v[31] ? -v : v;
        top = 0;
        for (k = 0; k < 32; k++)
            if (mag[k])
                top = k;
        if (top >= 23)
            frac = mag >> (top - 23);
        else
            frac = mag << (23 - top);
        return {v[31], 8'(127 + top), frac[22:0]};
    endfunction

    function automatic logic [31:0] int_from_float(input logic [31:0] f);
        int          e;
        logic [31:0] m;
        logic [31:0] mag;
        e = int'(f[30:23]) - 127;
        m = {8'd0, 1'b1, f[22:0]};
        if (f[30:23] == 8'hff && f[22:0] != 23'd0)
            return 32'h7fffffff;
        if (e < 0)
            return 32'd0;
        if (e >= 31)
            return f[31] ? 32'h80000000 : 32'h7fffffff;
        if (e >= 23)
            mag = m << (e - 23);
        else
            mag = m >> (23 - e);
        return f[31] ? -mag : mag;
    endfunction

    ////////////////////
    // Driver and checks
    ////////////////////

    task automatic check_val(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_test(input string test_name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", test_name, checks - c0, errors - e0);
    endtask

    // One four-phase transaction, outputs sampled at the falling edge
    task automatic do_op(input logic [3:0] code, input logic [31:0] a, input logic [31:0] b,
                         output logic [31:0] res, output logic [1:0] flg);
        int n;
        res = '0;
        flg = '0;
        if (timed_out)
            return;
        @(posedge clk);
        op1       <= a;
        op2       <= b;
        operation <= code;
        req       <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            $display("timeout: ack never rose for operation code %0d", code);
            timed_out = 1'b1;
            return;
        end
        res = result;
        flg = flag;
        @(posedge clk);
        req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            $display("timeout: ack stayed high after req fell, code %0d", code);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_and_compare(input string test_name, input logic [3:0] code,
                                   input logic [31:0] a, input logic [31:0] b,
                                   input logic [31:0] exp_res, input logic [1:0] exp_flg);
        logic [31:0] got_res;
        logic [1:0]  got_flg;
        do_op(code, a, b, got_res, got_flg);
        check_val(test_name, "result", exp_res, got_res);
        check_val(test_name, "flag", {30'd0, exp_flg}, {30'd0, got_flg});
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_arith();
        int          i;
        int          c0;
        int          e0;
        logic [3:0]  code;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_res;
        logic [1:0]  exp_flg;
        c0 = checks;
        e0 = errors;
        for (i = 0; i < 40; i++) begin
            code = 4'(i % 4);
            a = $random(seed);
            b = $random(seed);
            // Corners: add overflow, zero difference, divide by zero
            if (i == 0) begin
                a = 32'h7fffffff;
                b = 32'd1;
            end
            if (i == 5)
                b = a;
            if (i == 7)
                b = 32'd0;
            // Small factors so some products fit
            if (code == 4'd2 && i % 8 == 2) begin
                a = $signed(a) >>> 16;
                b = $signed(b) >>> 18;
            end
            arith_expect(code, a, b, exp_res, exp_flg);
            run_and_compare("test_arith", code, a, b, exp_res, exp_flg);
        end
        report_test("test_arith", c0, e0);
    endtask

    task automatic test_logic();
        int          i;
        int          c0;
        int          e0;
        logic [3:0]  code;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_res;
        c0 = checks;
        e0 = errors;
        for (i = 0; i < 20; i++) begin
            code = 4'(4 + i % 4);
            a = (i == 0) ? 32'hffffffff : $random(seed);
            b = $random(seed);
            case (code)
                4'd4:    exp_res = ~a;
                4'd5:    exp_res = a & b;
                4'd6:    exp_res = a | b;
                default: exp_res = a ^ b;
            endcase
            run_and_compare("test_logic", code, a, b, exp_res, zero_only(exp_res));
        end
        report_test("test_logic", c0, e0);
    endtask

    task automatic test_pack();
        int          i;
        int          c0;
        int          e0;
        logic [3:0]  code;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_res;
        c0 = checks;
        e0 = errors;
        // Codes 12 and 13 must behave like 8 and 9
        for (i = 0; i < 8; i++) begin
            code = (i % 4 == 0) ? 4'd8 : (i % 4 == 1) ? 4'd9 : (i % 4 == 2) ? 4'd12 : 4'd13;
            a = $random(seed);
            b = $random(seed);
            if (code[0] == 1'b0)
                exp_res = {b[15:0], a[15:0]};
            else
                exp_res = {a[31:16], b[15:0]};
            run_and_compare("test_pack", code, a, b, exp_res, zero_only(exp_res));
        end
        report_test("test_pack", c0, e0);
    endtask

    task automatic test_convert();
        int          i;
        int          c0;
        int          e0;
        int          e;
        logic [31:0] v;
        logic [31:0] f;
        c0 = checks;
        e0 = errors;
        for (i = 0; i < 10; i++) begin
            case (i)
                0:       v = 32'd0;
                1:       v = 32'd1;
                2:       v = 32'hffffffff;
                3:       v = 32'h7fffffff;
                default: v = $random(seed);
            endcase
            run_and_compare("test_convert itof", 4'd10, v, 32'd0, float_from_int(v), 2'd0);
        end
        for (i = 0; i < 11; i++) begin
            case (i)
                0: f = 32'h3f000000;  // 0.5
                1: f = 32'hc0700000;  // -3.75
                2: f = 32'h4f000000;  // 2^31
                3: f = 32'hff800000;  // -inf
                4: f = 32'hffc00000;  // quiet NaN with the sign bit set
                default: begin
                    e = 127 + int'($unsigned($random(seed)) % 31);
                    f = {1'($random(seed)), 8'(e), 23'($random(seed))};
                end
            endcase
            run_and_compare("test_convert ftoi", 4'd11, f, 32'd0, int_from_float(f), 2'd0);
        end
        report_test("test_convert", c0, e0);
    endtask

    task automatic test_handshake();
        int          n;
        int          c0;
        int          e0;
        int          stable;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] held;
        c0 = checks;
        e0 = errors;
        check_val("test_handshake", "ack after reset", 32'd0, {31'd0, ack_at_reset});
        check_val("test_handshake", "result after reset", 32'd0, res_at_reset);
        check_val("test_handshake", "flag after reset", 32'd0, {30'd0, flg_at_reset});
        a = $random(seed);
        b = $random(seed);
        @(posedge clk);
        op1       <= a;
        op2       <= b;
        operation <= 4'd7;
        req       <= 1'b1;
        // Edges counted from the one that launched req
        n = 0;
        while (n < TIMEOUT) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (ack)
                break;
        end
        if (!ack) begin
            $display("timeout: ack never rose in test_handshake");
            timed_out = 1'b1;
            return;
        end
        check_val("test_handshake", "edges to ack", 32'd2, 32'(n));
        check_val("test_handshake", "result", a ^ b, result);
        held = result;
        stable = 0;
        repeat (10) begin
            @(negedge clk);
            if (ack && result === held)
                stable++;
        end
        check_val("test_handshake", "stable hold cycles", 32'd10, 32'(stable));
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_val("test_handshake", "ack as req falls", 32'd1, {31'd0, ack});
        @(negedge clk);
        check_val("test_handshake", "ack one cycle later", 32'd0, {31'd0, ack});
        report_test("test_handshake", c0, e0);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (!arst_n && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!arst_n) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
            return;
        end
        @(negedge clk);
        ack_at_reset = ack;
        res_at_reset = result;
        flg_at_reset = flag;
    endtask

    initial begin
        req       = 1'b0;
        op1       = '0;
        op2       = '0;
        operation = '0;
        wait_reset();
        if (!timed_out)
            test_arith();
        if (!timed_out)
            test_logic();
        if (!timed_out)
            test_pack();
        if (!timed_out)
            test_convert();
        if (!timed_out)
            test_handshake();
        $display("total: %0d checks, %0d errors, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: flist.f
hw/alu_pkg.sv
hw/exec_if.sv
hw/int_arith_unit.sv
hw/int_to_float.sv
hw/float_to_int.sv
hw/int_alu.sv
hw/alu_top.sv
sim/tb_clock.sv
sim/tb_alu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_alu -o tb_alu_sim

./obj_dir/tb_alu_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
fi

echo "run_sim: simulation did not pass"
exit 1
